// File: src.f
+incdir+design
design/uart_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_csrs.sv
design/uart_top.sv
tests/uart_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile the uart testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module uart_tb -Mdir obj_dir -o uart_tb_sim
./obj_dir/uart_tb_sim

// File: tests/uart_tb.sv
// uart testbench with txd looped back to rxd
// reset state, loopback table, bit timing, back-pressure, cts gating, soft reset
`timescale 1ns/1ps
`default_nettype none
`include "uart_consts.svh"

module uart_tb;

   typedef struct packed {
      logic [15:0] div;  // bit time in cycles
      logic [7:0]  data;
      logic        rnd;  // data replaced by a random byte
      logic        bp;   // second write right behind the first
   } test_entry_t;

   localparam int NUM_TESTS = 6;
   localparam int EXTRA_DIV = 16; // cts and soft reset runs

   test_entry_t tests [NUM_TESTS] = '{
      {16'd16, 8'hA5, 1'b0, 1'b0},
      {16'd16, 8'hFF, 1'b0, 1'b0}, // start bit alone is low
      {16'd23, 8'h00, 1'b1, 1'b0},
      {16'd16, 8'h3C, 1'b0, 1'b1},
      {16'd32, 8'h00, 1'b1, 1'b1},
      {16'd9,  8'h81, 1'b0, 1'b0}
   };

   logic                    clk_i;
   logic                    arst_i;
   logic                    req_valid_i;
   uart_pkg::uart_bus_req_t req_i;
   wire                     req_ready_o;
   wire                     rsp_valid_o;
   uart_pkg::uart_bus_rsp_t rsp_o;
   wire                     txd_o;
   wire                     rts_o;
   wire                     cts_i;
   logic                    cts_force;
   logic                    stall_seen;
   int                      cur_div;

   assign cts_i = cts_force ? rts_o : 1'b0; // cts low while not forced

   uart_top dut0 (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .req_valid_i (req_valid_i),
      .req_i       (req_i),
      .req_ready_o (req_ready_o),
      .rsp_valid_o (rsp_valid_o),
      .rsp_o       (rsp_o),
      .rxd_i       (txd_o),  // loopback
      .txd_o       (txd_o),
      .cts_i       (cts_i),
      .rts_o       (rts_o)
   );

   always #4 clk_i = ~clk_i;

   ////////////////////
   // checks and bus tasks
   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (expected !== actual) begin
         $display("FAILED at %0t ns: %s expected 0x%0h, actual 0x%0h",
                  $time, name, expected, actual);
         $display("Simulation failed");
         $fatal(1, "wrong value on %s", name);
      end
   endtask

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1, "%s", why);
   endtask

   task automatic bus_request(input logic we, input logic [1:0] addr, input logic [31:0] data);
      int waits;
      waits = 0;
      @(posedge clk_i);
      req_valid_i <= 1'b1;
      req_i.addr  <= addr;
      req_i.we    <= we;
      req_i.wdata <= data;
      @(negedge clk_i);
      while (!req_ready_o) begin
         stall_seen = 1'b1;
         waits++;
         if (waits > 40 * cur_div + 100) stop_run("A bus request was never accepted.");
         @(negedge clk_i);
      end
      @(posedge clk_i); // accepted on this edge
      req_valid_i <= 1'b0;
   endtask

   task automatic bus_read(input logic [1:0] addr, output logic [31:0] data);
      int waits;
      waits = 0;
      bus_request(1'b0, addr, 32'd0);
      @(negedge clk_i);
      while (!rsp_valid_o) begin
         waits++;
         if (waits > 4) stop_run("A bus read got no response.");
         @(negedge clk_i);
      end
      data = rsp_o.rdata;
   endtask

   task automatic configure(input int div, input logic srst);
      cur_div = div;
      bus_request(1'b1, `UART_ADDR_CTRL, {1'b1, 1'b1, srst, 13'd0, 16'(div)});
   endtask

   task automatic wait_bits(input int bits);
      repeat (bits * cur_div) @(negedge clk_i);
   endtask

   // read status until a masked bit is set
   task automatic poll_status(input logic [31:0] mask);
      logic [31:0] st;
      int          polls;
      polls = 0;
      bus_read(`UART_ADDR_STATUS, st);
      while ((st & mask) == 32'd0) begin
         polls++;
         if (polls > 8 * cur_div + 20) stop_run("A status bit never came up while polling.");
         bus_read(`UART_ADDR_STATUS, st);
      end
   endtask

   task automatic receive_byte(input logic [7:0] expected);
      logic [31:0] rd;
      poll_status(32'd2);
      bus_read(`UART_ADDR_RXDATA, rd);
      check("rxdata", {24'd0, expected}, rd);
      bus_read(`UART_ADDR_STATUS, rd);
      check("status.rx_flag", 32'd0, {31'd0, rd[1]});
   endtask

   // low run on the line: start bit plus the low lsbs that follow it
   function automatic int low_run(input logic [7:0] data, input int div);
      logic [7:0] rest;
      int         bits;
      rest = data;
      bits = 1;
      while (bits < 9 && !rest[0]) begin
         bits++;
         rest = rest >> 1;
      end
      return bits * div;
   endfunction

   task automatic measure_start(input logic [7:0] data);
      int low;
      int waits;
      low   = 0;
      waits = 0;
      @(negedge clk_i);
      while (txd_o) begin
         waits++;
         if (waits > 8) stop_run("The start bit never appeared on txd_o.");
         @(negedge clk_i);
      end
      while (!txd_o && low < 12 * cur_div) begin
         low++;
         @(negedge clk_i);
      end
      check("txd_o low cycles", 32'(low_run(data, cur_div)), 32'(low));
   endtask

   ////////////////////
   // main sequence
   initial begin : main
      test_entry_t t;
      logic [7:0]  second;
      logic [31:0] rd;
      clk_i       = 1'b0;
      arst_i      <= 1'b0;
      req_valid_i <= 1'b0;
      req_i       <= '0;
      cts_force   <= 1'b1;
      stall_seen  = 1'b0;
      cur_div     = EXTRA_DIV;
      void'($urandom(81));
      repeat (10) @(posedge clk_i);
      arst_i <= 1'b1;
      @(negedge clk_i);
      check("txd_o", 32'd1, 32'(txd_o));
      check("rts_o", 32'd0, 32'(rts_o));
      check("req_ready_o", 32'd1, 32'(req_ready_o));
      bus_read(`UART_ADDR_STATUS, rd);
      check("status after reset", 32'd0, rd);

      for (int i = 0; i < NUM_TESTS; i++) begin
         t = tests[i];
         if (t.rnd) t.data = 8'($urandom);
         second = ~t.data;
         configure(int'(t.div), 1'b0);
         wait_bits(2); // receiver needs an idle bit time
         bus_request(1'b1, `UART_ADDR_TXDATA, {24'd0, t.data});
         if (t.bp) begin
            stall_seen = 1'b0;
            bus_request(1'b1, `UART_ADDR_TXDATA, {24'd0, second});
            check("req_ready_o low seen", 32'd1, 32'(stall_seen));
            receive_byte(t.data);
            receive_byte(second);
         end else begin
            measure_start(t.data);
            receive_byte(t.data);
         end
         poll_status(32'd1); // tx idle before the divisor changes
      end

      // cts held low blocks the frame
      configure(EXTRA_DIV, 1'b0);
      @(posedge clk_i);
      cts_force <= 1'b0;
      repeat (4) @(posedge clk_i);
      bus_read(`UART_ADDR_STATUS, rd);
      check("status with cts low", 32'd0, rd);
      fork
         bus_request(1'b1, `UART_ADDR_TXDATA, {24'd0, 8'h6E});
         begin
            repeat (30 * cur_div) begin
               @(negedge clk_i);
               check("txd_o while cts low", 32'd1, 32'(txd_o));
            end
            @(posedge clk_i);
            cts_force <= 1'b1;
         end
      join
      bus_read(`UART_ADDR_STATUS, rd);
      check("status.rx_flag after cts hold", 32'd0, {31'd0, rd[1]});
      receive_byte(8'h6E);
      poll_status(32'd1);

      // soft reset in the middle of a frame
      bus_request(1'b1, `UART_ADDR_TXDATA, {24'd0, 8'h5A});
      poll_status(32'd2); // byte left unread
      bus_request(1'b1, `UART_ADDR_TXDATA, {24'd0, 8'hF0}); // low in bits 0 to 3
      wait_bits(3);
      configure(EXTRA_DIV, 1'b1);
      repeat (4) @(negedge clk_i);
      check("txd_o in soft reset", 32'd1, 32'(txd_o));
      check("rts_o in soft reset", 32'd0, 32'(rts_o));
      bus_read(`UART_ADDR_STATUS, rd);
      check("status in soft reset", 32'd0, rd);
      configure(EXTRA_DIV, 1'b0);
      wait_bits(2);
      bus_request(1'b1, `UART_ADDR_TXDATA, {24'd0, 8'hC3});
      receive_byte(8'hC3);

      $display("Simulation completed successfully");
      $finish;
   end

   // 40 frame times per table entry and per extra run
   initial begin : watchdog
      longint budget;
      budget = 2000;
      for (int i = 0; i < NUM_TESTS; i++) begin
         budget += 400 * longint'(tests[i].div);
      end
      budget += 2 * 400 * EXTRA_DIV;
      repeat (budget) @(posedge clk_i);
      stop_run("Watchdog timeout, the tests did not finish in time.");
   end

endmodule

`default_nettype wire

// File: design/uart_top.sv
// uart peripheral top
// register block with transmitter and receiver, serial pins
`timescale 1ns/1ps
`default_nettype none

module uart_top (
   input  wire                      clk_i,
   input  wire                      arst_i,
   input  wire                      req_valid_i,
   input  wire uart_pkg::uart_bus_req_t req_i,
   output logic                     req_ready_o,
   output logic                     rsp_valid_o,
   output uart_pkg::uart_bus_rsp_t  rsp_o,
   input  wire                      rxd_i,
   output wire                      txd_o,
   input  wire                      cts_i,
   output logic                     rts_o
);

   uart_pkg::uart_ctrl_t ctrl;
   logic                 tx_valid;
   logic [7:0]           tx_byte;
   logic                 tx_ready;
   logic                 rx_valid;
   logic [7:0]           rx_byte;

   uart_csrs csrs0 (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .req_valid_i (req_valid_i),
      .req_i       (req_i),
      .req_ready_o (req_ready_o),
      .rsp_valid_o (rsp_valid_o),
      .rsp_o       (rsp_o),
      .ctrl_o      (ctrl),
      .tx_valid_o  (tx_valid),
      .tx_byte_o   (tx_byte),
      .tx_ready_i  (tx_ready),
      .rx_valid_i  (rx_valid),
      .rx_byte_i   (rx_byte)
   );

   uart_tx tx0 (
      .clk_i      (clk_i),
      .arst_i     (arst_i),
      .ctrl_i     (ctrl),
      .cts_i      (cts_i),
      .tx_valid_i (tx_valid),
      .tx_byte_i  (tx_byte),
      .tx_ready_o (tx_ready),
      .txd_o      (txd_o)
   );

   uart_rx rx0 (
      .clk_i      (clk_i),
      .arst_i     (arst_i),
      .ctrl_i     (ctrl),
      .rxd_i      (rxd_i),
      .rx_valid_o (rx_valid),
      .rx_byte_o  (rx_byte),
      .rts_o      (rts_o)
   );

endmodule

`default_nettype wire

// File: design/uart_csrs.sv
// uart register block
// address decode, control word, tx write back-pressure, rx byte and flag
`timescale 1ns/1ps
`default_nettype none
`include "uart_consts.svh"

module uart_csrs (
   input  wire                      clk_i,
   input  wire                      arst_i,
   input  wire                      req_valid_i,
   input  wire uart_pkg::uart_bus_req_t req_i,
   output logic                     req_ready_o,
   output logic                     rsp_valid_o,
   output uart_pkg::uart_bus_rsp_t  rsp_o,
   output uart_pkg::uart_ctrl_t     ctrl_o,
   output logic                     tx_valid_o,
   output logic [7:0]               tx_byte_o,
   input  wire                      tx_ready_i,
   input  wire                      rx_valid_i,
   input  wire [7:0]                rx_byte_i
);

   logic                   wr_tx;   // pending tx data write
   logic                   accept;
   logic                   wr_ctrl;
   logic                   rd_any;
   logic                   rd_rx;
   logic                   rx_flag;
   logic [7:0]             rx_byte_q;
   logic [`UART_BUS_W-1:0] rdata_mux;

   ////////////////////
   // request decode
   assign wr_tx       = req_valid_i & req_i.we & (req_i.addr == `UART_ADDR_TXDATA);
   assign tx_valid_o  = wr_tx;
   assign tx_byte_o   = req_i.wdata.tx.data;
   assign req_ready_o = ~wr_tx | tx_ready_i; // only tx writes stall
   assign accept      = req_valid_i & req_ready_o;
   assign wr_ctrl     = accept & req_i.we & (req_i.addr == `UART_ADDR_CTRL);
   assign rd_any      = accept & ~req_i.we;
   assign rd_rx       = rd_any & (req_i.addr == `UART_ADDR_RXDATA);

   always_comb begin
      case (req_i.addr)
         `UART_ADDR_CTRL:   rdata_mux = ctrl_o;
         `UART_ADDR_STATUS: rdata_mux = {{(`UART_BUS_W-2){1'b0}}, rx_flag, tx_ready_i};
         `UART_ADDR_RXDATA: rdata_mux = {{(`UART_BUS_W-8){1'b0}}, rx_byte_q};
         default:           rdata_mux = '0; // tx data reads as zero
      endcase
   end

   ////////////////////
   // registers
   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i)      ctrl_o <= '0;
      else if (wr_ctrl) ctrl_o <= req_i.wdata.ctrl;
   end

   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i) rsp_valid_o <= 1'b0;
      else         rsp_valid_o <= rd_any; // cycle after acceptance
   end

   always_ff @(posedge clk_i) begin
      if (rd_any) rsp_o.rdata <= rdata_mux;
   end

   // new byte wins over a same cycle read
   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i)              rx_flag <= 1'b0;
      else if (ctrl_o.soft_rst) rx_flag <= 1'b0;
      else if (rx_valid_i)      rx_flag <= 1'b1;
      else if (rd_rx)           rx_flag <= 1'b0;
   end

   always_ff @(posedge clk_i) begin
      if (rx_valid_i) rx_byte_q <= rx_byte_i; // unread byte is overwritten
   end

endmodule

`default_nettype wire

// File: design/uart_rx.sv
// uart receiver
// idle line sync, start bit centering, data sampling and rts
`timescale 1ns/1ps
`default_nettype none
`include "uart_consts.svh"

module uart_rx (
   input  wire                  clk_i,
   input  wire                  arst_i,
   input  wire uart_pkg::uart_ctrl_t ctrl_i,
   input  wire                  rxd_i,
   output logic                 rx_valid_o,
   output logic [7:0]           rx_byte_o,
   output logic                 rts_o
);

   localparam logic [2:0] RX_SYNC   = 3'd0; // wait for high line
   localparam logic [2:0] RX_IDLE   = 3'd1; // high for one bit time
   localparam logic [2:0] RX_START  = 3'd2; // wait for falling edge
   localparam logic [2:0] RX_CENTER = 3'd3; // half bit into start
   localparam logic [2:0] RX_DATA   = 3'd4; // data bits, then stop

   logic [2:0]             rx_pc;
   logic [`UART_DIV_W-1:0] rx_cyclecnt;
   logic [3:0]             rx_bitcnt;
   logic [7:0]             rx_shift;
   logic                   rx_run;
   logic                   sample_en;

   assign rx_run    = ctrl_i.rx_en & ~ctrl_i.soft_rst;
   assign sample_en = rx_run && (rx_pc == RX_DATA)
                      && (rx_cyclecnt == ctrl_i.bit_duration);

   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i) rts_o <= 1'b0;
      else         rts_o <= rx_run;
   end

   // data path, one sample per bit time
   always_ff @(posedge clk_i) begin
      if (sample_en) begin
         if (rx_bitcnt == 4'd8) rx_byte_o <= rx_shift; // stop bit sample
         else                   rx_shift  <= {rxd_i, rx_shift[7:1]};
      end
   end

   ////////////////////
   // receive program
   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i) begin
         rx_pc       <= RX_SYNC;
         rx_cyclecnt <= `UART_DIV_W'(1);
         rx_bitcnt   <= 4'd0;
         rx_valid_o  <= 1'b0;
      end else if (!rx_run) begin
         rx_pc       <= RX_SYNC;
         rx_cyclecnt <= `UART_DIV_W'(1);
         rx_bitcnt   <= 4'd0;
         rx_valid_o  <= 1'b0;
      end else begin
         rx_valid_o <= 1'b0; // one cycle pulse
         case (rx_pc)
            RX_SYNC: begin
               rx_cyclecnt <= `UART_DIV_W'(1);
               rx_bitcnt   <= 4'd0;
               if (rxd_i) rx_pc <= RX_IDLE;
            end
            RX_IDLE: begin
               if (!rxd_i) begin
                  rx_pc <= RX_SYNC;  // glitch, start over
               end else if (rx_cyclecnt == ctrl_i.bit_duration) begin
                  rx_pc <= RX_START;
               end else begin
                  rx_cyclecnt <= rx_cyclecnt + `UART_DIV_W'(1);
               end
            end
            RX_START: begin
               rx_cyclecnt <= `UART_DIV_W'(1);
               if (!rxd_i) rx_pc <= RX_CENTER;
            end
            RX_CENTER: begin
               if (rx_cyclecnt == (ctrl_i.bit_duration >> 1)) begin
                  rx_cyclecnt <= `UART_DIV_W'(1);
                  if (rxd_i) rx_pc <= RX_SYNC; // false start
                  else       rx_pc <= RX_DATA;
               end else begin
                  rx_cyclecnt <= rx_cyclecnt + `UART_DIV_W'(1);
               end
            end
            RX_DATA: begin
               if (sample_en) begin
                  rx_cyclecnt <= `UART_DIV_W'(1);
                  if (rx_bitcnt == 4'd8) begin
                     rx_valid_o <= 1'b1;
                     rx_bitcnt  <= 4'd0;
                     rx_pc      <= RX_START; // straight to next frame
                  end else begin
                     rx_bitcnt <= rx_bitcnt + 4'd1;
                  end
               end else begin
                  rx_cyclecnt <= rx_cyclecnt + `UART_DIV_W'(1);
               end
            end
            default: rx_pc <= RX_SYNC;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: design/uart_tx.sv
// uart transmitter
// cts synchronizer and 8N1 frame serializer with valid/ready byte input
`timescale 1ns/1ps
`default_nettype none
`include "uart_consts.svh"

module uart_tx (
   input  wire                  clk_i,
   input  wire                  arst_i,
   input  wire uart_pkg::uart_ctrl_t ctrl_i,
   input  wire                  cts_i,
   input  wire                  tx_valid_i,
   input  wire [7:0]            tx_byte_i,
   output logic                 tx_ready_o,
   output wire                  txd_o
);

   localparam logic [1:0] TX_WAIT = 2'd0; // wait for a byte
   localparam logic [1:0] TX_LOAD = 2'd1; // build the frame
   localparam logic [1:0] TX_SEND = 2'd2; // shift it out

   logic [1:0]             cts_q;
   logic [1:0]             tx_pc;
   logic [9:0]             tx_pattern;  // stop, data, start
   logic [3:0]             tx_bitcnt;
   logic [`UART_DIV_W-1:0] tx_cyclecnt;
   logic [7:0]             tx_byte_q;
   logic                   tx_run;

   assign txd_o  = tx_pattern[0];
   assign tx_run = ctrl_i.tx_en & ~ctrl_i.soft_rst & cts_q[1];

   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i) cts_q <= 2'b00;
      else         cts_q <= {cts_q[0], cts_i}; // two flop sync
   end

   always_ff @(posedge clk_i) begin
      if (tx_valid_i && tx_ready_o) tx_byte_q <= tx_byte_i;
   end

   ////////////////////
   // frame program
   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i) begin
         tx_pc       <= TX_WAIT;
         tx_ready_o  <= 1'b0;
         tx_pattern  <= '1;
         tx_bitcnt   <= 4'd0;
         tx_cyclecnt <= `UART_DIV_W'(1);
      end else if (!tx_run) begin // disabled, soft reset or cts low
         tx_pc       <= TX_WAIT;
         tx_ready_o  <= 1'b0;
         tx_pattern  <= '1;
         tx_bitcnt   <= 4'd0;
         tx_cyclecnt <= `UART_DIV_W'(1);
      end else begin
         case (tx_pc)
            TX_WAIT: begin
               tx_pattern  <= '1;      // line idles high
               tx_bitcnt   <= 4'd0;
               tx_cyclecnt <= `UART_DIV_W'(1);
               if (tx_valid_i && tx_ready_o) begin
                  tx_ready_o <= 1'b0;
                  tx_pc      <= TX_LOAD;
               end else begin
                  tx_ready_o <= 1'b1;
               end
            end
            TX_LOAD: begin
               tx_pattern <= {1'b1, tx_byte_q, 1'b0};
               tx_pc      <= TX_SEND;
            end
            TX_SEND: begin
               if (tx_cyclecnt == ctrl_i.bit_duration) begin
                  tx_cyclecnt <= `UART_DIV_W'(1);
                  if (tx_bitcnt == 4'd9) begin // stop bit done
                     tx_pc <= TX_WAIT;
                  end else begin
                     tx_pattern <= {1'b1, tx_pattern[9:1]}; // lsb first
                     tx_bitcnt  <= tx_bitcnt + 4'd1;
                  end
               end else begin
                  tx_cyclecnt <= tx_cyclecnt + `UART_DIV_W'(1);
               end
            end
            default: tx_pc <= TX_WAIT;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: design/uart_pkg.sv
// uart shared types
// bus request and response, control word, write data views
`default_nettype none
`include "uart_consts.svh"

package uart_pkg;

   typedef struct packed {
      logic                                  tx_en;        // transmitter on
      logic                                  rx_en;        // receiver on
      logic                                  soft_rst;     // level, held until cleared
      logic [`UART_BUS_W-`UART_DIV_W-4:0]    rsvd;
      logic [`UART_DIV_W-1:0]                bit_duration; // cycles per bit
   } uart_ctrl_t;

   typedef struct packed {
      logic [`UART_BUS_W-9:0] unused;
      logic [7:0]             data;   // byte to send
   } uart_txword_t;

   // one write word, read per address
   typedef union packed {
      uart_ctrl_t   ctrl; // at the control address
      uart_txword_t tx;   // at the tx data address
   } uart_wdata_u;

   typedef struct packed {
      logic [1:0]  addr;
      logic        we;
      uart_wdata_u wdata;
   } uart_bus_req_t;

   typedef struct packed {
      logic [`UART_BUS_W-1:0] rdata;
   } uart_bus_rsp_t;

endpackage

`default_nettype wire

// File: design/uart_consts.svh
// uart widths and register word addresses
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// bit time divisor, in clock cycles
`define UART_DIV_W 16

// register bus data width
`define UART_BUS_W 32

// word addresses on the register bus
`define UART_ADDR_CTRL   2'd0 // control word
`define UART_ADDR_STATUS 2'd1 // rx flag, tx ready
`define UART_ADDR_TXDATA 2'd2 // byte to send
`define UART_ADDR_RXDATA 2'd3 // last byte received

`endif
